// ==== common/nabp_consts.svh ====
`ifndef NABP_CONSTS_SVH
`define NABP_CONSTS_SVH

// last partition index, tap line holds one more than this
`define NABP_PARTITIONS 3

// column steps per angle
`define NABP_IMAGE_SIZE 16

// accumulator fraction bits, one integer bit above them
`define NABP_ACCU_FRAC 8

// filtered sample width
`define NABP_SAMPLE_W 12

// angle table depth and index width
`define NABP_ANGLES 8
`define NABP_ANGLE_W 3

`endif

// ==== common/nabp_pkg.sv ====
`include "nabp_consts.svh"

package nabp_pkg;

    // unsigned fixed point, 1 integer bit over the fraction
    typedef logic [`NABP_ACCU_FRAC:0] accu_t;

    // filtered projection sample
    typedef logic [`NABP_SAMPLE_W-1:0] sample_t;

    // index into the angle table
    typedef logic [`NABP_ANGLE_W-1:0] angle_t;

    // shifter phases
    typedef enum logic [1:0]
    {
        ready_s,
        fill_s,
        fill_done_s,
        shift_s
    } shifter_state_t;

endpackage

// ==== verilog/nabp_shifter_lut.sv ====
`timescale 1ns/1ps

module nabp_shifter_lut
    import nabp_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  angle_t angle,
    output accu_t  accu_base
);

    accu_t step;

    // per-angle accumulator step, 1.0 is 9'h100
    always_comb
    begin
        case (angle)
            3'd0: step = 9'h080;
            3'd1: step = 9'h100;
            3'd2: step = 9'h000;
            3'd3: step = 9'h040;
            3'd4: step = 9'h0c0;
            3'd5: step = 9'h060;
            3'd6: step = 9'h0a0;
            3'd7: step = 9'h020;
            default: step = 9'h000;
        endcase
    end

    // one register stage on the read
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            accu_base <= '0;
        end
        else
        begin
            accu_base <= step;
        end
    end

endmodule

// ==== shifter/nabp_shifter.sv ====
`timescale 1ns/1ps
`include "nabp_consts.svh"

module nabp_shifter
    import nabp_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  accu_t accu_base,
    input  logic  fill_kick,
    input  logic  shift_kick,
    input  logic  shift_taken,
    output logic  fill_done,
    output logic  shift_done,
    output logic  shift_en,
    output logic  column_valid
);

    localparam int fill_len = `NABP_PARTITIONS + 1;
    localparam int fill_w   = $clog2(fill_len + 1);
    localparam int col_w    = $clog2(`NABP_IMAGE_SIZE);
    localparam int int_bit  = `NABP_ACCU_FRAC;

    shifter_state_t    state;
    shifter_state_t    next_state;
    logic [fill_w-1:0] fill_cnt;
    logic [col_w-1:0]  col_cnt;
    accu_t             accu;
    accu_t             accu_next;
    logic              crossing;
    logic              step_done;

    // accumulator wraps freely since only the integer bit flip matters
    always_comb
    begin
        accu_next = accu + accu_base;
        crossing  = accu_next[int_bit] != accu[int_bit];
        step_done = (state == shift_s) && (!crossing || shift_taken);
    end

    // request a sample while filling, or on a column that crosses a boundary
    assign shift_en = ((state == fill_s) && (fill_cnt != '0)) ||
                      ((state == shift_s) && crossing);

    // last fill sample taken
    assign fill_done = (state == fill_s) && (fill_cnt == fill_w'(1)) && shift_taken;

    // final column step completes
    assign shift_done = step_done && (col_cnt == col_w'(`NABP_IMAGE_SIZE - 1));

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (fill_kick)
                    next_state = fill_s;
            fill_s:
                if (fill_done)
                    next_state = fill_done_s;
            fill_done_s:
                if (shift_kick)
                    next_state = shift_s;
            shift_s:
                if (shift_done)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state        <= ready_s;
            fill_cnt     <= fill_w'(fill_len);
            col_cnt      <= '0;
            accu         <= '0;
            column_valid <= 1'b0;
        end
        else
        begin
            state        <= next_state;
            column_valid <= step_done;

            // fill counter reloads outside the fill phase
            if (state == fill_s)
            begin
                if (shift_taken)
                    fill_cnt <= fill_cnt - fill_w'(1);
            end
            else
            begin
                fill_cnt <= fill_w'(fill_len);
            end

            // each shift phase starts from zero
            if (state == shift_s)
            begin
                if (step_done)
                begin
                    accu    <= accu_next;
                    col_cnt <= col_cnt + col_w'(1);
                end
            end
            else
            begin
                accu    <= '0;
                col_cnt <= '0;
            end
        end
    end

endmodule

// ==== verilog/nabp_filter_mapper.sv ====
`timescale 1ns/1ps
`include "nabp_consts.svh"

module nabp_filter_mapper
    import nabp_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    shift_en,
    input  logic    sample_valid,
    input  sample_t sample_data,
    output logic    shift_taken,
    output sample_t column_sample
);

    // tap 0 is the newest sample
    sample_t taps [0:`NABP_PARTITIONS];

    // a request is served only when the stream has data
    assign shift_taken = shift_en && sample_valid;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i <= `NABP_PARTITIONS; i++)
            begin
                taps[i] <= '0;
            end
        end
        else if (shift_taken)
        begin
            taps[0] <= sample_data;
            for (int i = 1; i <= `NABP_PARTITIONS; i++)
            begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // older taps feed the partition PEs, only the newest goes out here
    assign column_sample = taps[0];

endmodule

// ==== verilog/nabp_state_control.sv ====
`timescale 1ns/1ps
`include "nabp_consts.svh"

module nabp_state_control
    import nabp_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   start,
    input  angle_t first_angle,
    input  angle_t angle_count,
    input  logic   fill_done,
    input  logic   shift_done,
    output angle_t angle,
    output logic   fill_kick,
    output logic   shift_kick,
    output logic   busy,
    output logic   done
);

    localparam int count_w = `NABP_ANGLE_W + 1;

    typedef enum logic [2:0]
    {
        idle_s,
        lut_s,
        fill_kick_s,
        fill_wait_s,
        shift_kick_s,
        shift_wait_s
    } sc_state_t;

    sc_state_t          state;
    logic [count_w-1:0] remaining;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state     <= idle_s;
            angle     <= '0;
            remaining <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                idle_s:
                    if (start)
                    begin
                        busy  <= 1'b1;
                        angle <= first_angle;
                        // zero count runs the whole table
                        remaining <= (angle_count == '0) ? count_w'(`NABP_ANGLES)
                                                         : {1'b0, angle_count};
                        state <= lut_s;
                    end
                // wait out the registered table read
                lut_s:
                    state <= fill_kick_s;
                fill_kick_s:
                    state <= fill_wait_s;
                fill_wait_s:
                    if (fill_done)
                        state <= shift_kick_s;
                shift_kick_s:
                    state <= shift_wait_s;
                shift_wait_s:
                    if (shift_done)
                    begin
                        if (remaining == count_w'(1))
                        begin
                            busy  <= 1'b0;
                            done  <= 1'b1;
                            state <= idle_s;
                        end
                        else
                        begin
                            // index wraps modulo the table depth
                            angle     <= angle + angle_t'(1);
                            remaining <= remaining - count_w'(1);
                            state     <= lut_s;
                        end
                    end
                default:
                    state <= idle_s;
            endcase
        end
    end

    assign fill_kick  = (state == fill_kick_s);
    assign shift_kick = (state == shift_kick_s);

endmodule

// ==== verilog/nabp_top.sv ====
`timescale 1ns/1ps

module nabp_top
    import nabp_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    start,
    input  angle_t  first_angle,
    input  angle_t  angle_count,
    input  sample_t sample_data,
    input  logic    sample_valid,
    output logic    sample_ready,
    output logic    column_valid,
    output sample_t column_sample,
    output logic    busy,
    output logic    done
);

    angle_t angle;
    accu_t  accu_base;
    logic   fill_kick;
    logic   shift_kick;
    logic   fill_done;
    logic   shift_done;
    logic   shift_en;
    logic   shift_taken;

    nabp_state_control state_control0
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .start       (start),
        .first_angle (first_angle),
        .angle_count (angle_count),
        .fill_done   (fill_done),
        .shift_done  (shift_done),
        .angle       (angle),
        .fill_kick   (fill_kick),
        .shift_kick  (shift_kick),
        .busy        (busy),
        .done        (done)
    );

    nabp_shifter_lut shifter_lut0
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .angle     (angle),
        .accu_base (accu_base)
    );

    nabp_shifter shifter0
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .accu_base    (accu_base),
        .fill_kick    (fill_kick),
        .shift_kick   (shift_kick),
        .shift_taken  (shift_taken),
        .fill_done    (fill_done),
        .shift_done   (shift_done),
        .shift_en     (shift_en),
        .column_valid (column_valid)
    );

    nabp_filter_mapper filter_mapper0
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .shift_en      (shift_en),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .shift_taken   (shift_taken),
        .column_sample (column_sample)
    );

    // the sample source sees the shifter's request directly
    assign sample_ready = shift_en;

endmodule

// ==== sim/nabp_tb.sv ====
`timescale 1ns/1ps

module nabp_tb
    import nabp_pkg::*;
();

    logic    clk;
    logic    reset_n;
    logic    start;
    angle_t  first_angle;
    angle_t  angle_count;
    sample_t sample_data;
    logic    sample_valid;
    logic    sample_ready;
    logic    column_valid;
    sample_t column_sample;
    logic    busy;
    logic    done;

    int      fd;
    string   test_name;
    sample_t stream [$];
    sample_t expect_q [$];
    int      sample_idx;
    int      col_idx;
    int      done_count;
    int      test_errors;
    int      pass_count;
    int      fail_count;
    bit      stall_en;
    bit      overrun;

    nabp_top dut0
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .start         (start),
        .first_angle   (first_angle),
        .angle_count   (angle_count),
        .sample_data   (sample_data),
        .sample_valid  (sample_valid),
        .sample_ready  (sample_ready),
        .column_valid  (column_valid),
        .column_sample (column_sample),
        .busy          (busy),
        .done          (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    // next whitespace token past any # comment lines
    task automatic read_token(output string tok);
        logic [1023:0] rest;
        int            n;
        bit            found;
        found = 1'b0;
        tok   = "";
        while (!found)
        begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1)
            begin
                tok   = "";
                found = 1'b1;
            end
            else if (tok.substr(0, 0) == "#")
            begin
                n = $fgets(rest, fd);
            end
            else
            begin
                found = 1'b1;
            end
        end
    endtask

    task automatic read_value(output int v);
        string tok;
        int    n;
        v = 0;
        read_token(tok);
        if (tok == "")
            abort_run("the golden file ends in the middle of a test");
        else
            n = $sscanf(tok, "%h", v);
    endtask

    // a count followed by that many values
    task automatic read_list(input bit to_expect);
        int count;
        int v;
        read_value(count);
        if (to_expect)
            expect_q.delete();
        else
            stream.delete();
        for (int i = 0; i < count; i++)
        begin
            read_value(v);
            if (to_expect)
                expect_q.push_back(sample_t'(v));
            else
                stream.push_back(sample_t'(v));
        end
    endtask

    task automatic drive_sample();
        if (sample_idx < stream.size())
        begin
            sample_data  = stream[sample_idx];
            sample_valid = !stall_en || (($urandom % 4) != 0);
        end
        else
        begin
            sample_data  = '0;
            sample_valid = 1'b0;
        end
    endtask

    // outputs checked mid-cycle while inputs change 1 ns after the edge
    task automatic step_cycle();
        @(negedge clk);
        if (column_valid)
        begin
            if (col_idx >= expect_q.size())
            begin
                $display("test %s produced more columns than expected", test_name);
                test_errors++;
            end
            else if (column_sample !== expect_q[col_idx])
            begin
                $display("** Error %s column %0d: expected %h, actual %h",
                         test_name, col_idx, expect_q[col_idx], column_sample);
                test_errors++;
            end
            col_idx++;
        end
        if (done)
        begin
            done_count++;
            if (busy !== 1'b0)
            begin
                $display("** Error %s: busy with done expected 0, actual %b", test_name, busy);
                test_errors++;
            end
        end
        if (sample_ready && sample_valid)
            sample_idx++;
        else if (sample_ready && !overrun && sample_idx >= stream.size())
        begin
            $display("test %s asked for a sample beyond the end of its stream", test_name);
            overrun = 1'b1;
            test_errors++;
        end
        @(posedge clk);
        #1;
        drive_sample();
    endtask

    task automatic wait_for_done(input int limit);
        int cycles;
        cycles = 0;
        while (done_count == 0 && cycles < limit)
        begin
            step_cycle();
            cycles++;
        end
        if (done_count == 0)
            abort_run($sformatf("test %s timed out waiting for done", test_name));
    endtask

    task automatic wait_for_columns(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (col_idx < n && cycles < limit)
        begin
            step_cycle();
            cycles++;
        end
        if (col_idx < n)
            abort_run($sformatf("test %s timed out waiting for columns", test_name));
    endtask

    task automatic start_run(input angle_t first, input angle_t count);
        first_angle = first;
        angle_count = count;
        start       = 1'b1;
        step_cycle();
        start = 1'b0;
    endtask

    task automatic clear_progress();
        sample_idx = 0;
        col_idx    = 0;
        done_count = 0;
        overrun    = 1'b0;
    endtask

    task automatic check_low(input string what, input logic actual);
        if (actual !== 1'b0)
        begin
            $display("** Error %s: %s expected 0, actual %b", test_name, what, actual);
            test_errors++;
        end
    endtask

    // mode 0 plain, 1 random stalls on the previous data, 2 reset during a run first
    task automatic run_test(input string name);
        int first;
        int count;
        int mode;
        test_name = name;
        read_value(first);
        read_value(count);
        read_value(mode);
        if (mode != 1)
        begin
            read_list(1'b0);
            read_list(1'b1);
        end
        test_errors = 0;
        stall_en    = 1'b0;
        clear_progress();
        drive_sample();
        if (mode == 2)
        begin
            start_run(angle_t'(first), angle_t'(count));
            wait_for_columns(5, 500);
            reset_n = 1'b0;
            repeat (4) step_cycle();
            reset_n = 1'b1;
            step_cycle();
            check_low("busy", busy);
            check_low("done", done);
            check_low("sample_ready", sample_ready);
            check_low("column_valid", column_valid);
            clear_progress();
            drive_sample();
        end
        stall_en = (mode == 1);
        start_run(angle_t'(first), angle_t'(count));
        // busy rises on the edge that took start
        if (busy !== 1'b1)
        begin
            $display("** Error %s busy after start: expected 1, actual %b", name, busy);
            test_errors++;
        end
        wait_for_done(3000);
        // quiet period to catch a second done or stray columns
        repeat (6) step_cycle();
        if (done_count != 1)
        begin
            $display("test %s saw done pulse %0d times instead of once", name, done_count);
            test_errors++;
        end
        if (col_idx != expect_q.size())
        begin
            $display("** Error %s column count: expected %0d, actual %0d",
                     name, expect_q.size(), col_idx);
            test_errors++;
        end
        if (sample_idx != stream.size())
        begin
            $display("** Error %s samples taken: expected %0d, actual %0d",
                     name, stream.size(), sample_idx);
            test_errors++;
        end
        check_low("busy", busy);
        if (test_errors == 0)
        begin
            $display("test %s: passed, %0d columns", name, col_idx);
            pass_count++;
        end
        else
        begin
            $display("test %s: failed with %0d errors", name, test_errors);
            fail_count++;
        end
        stall_en = 1'b0;
    endtask

    initial
    begin : main
        string tok;
        reset_n      = 1'b0;
        start        = 1'b0;
        first_angle  = '0;
        angle_count  = '0;
        sample_data  = '0;
        sample_valid = 1'b0;
        pass_count   = 0;
        fail_count   = 0;
        test_errors  = 0;
        stall_en     = 1'b0;
        test_name    = "reset";
        clear_progress();
        void'($urandom(77));
        fd = $fopen("sim/nabp_golden.txt", "r");
        if (fd == 0)
        begin
            abort_run("cannot open sim/nabp_golden.txt");
        end
        else
        begin
            repeat (8) step_cycle();
            reset_n = 1'b1;
            step_cycle();
            read_token(tok);
            while (tok != "")
            begin
                run_test(tok);
                read_token(tok);
            end
            $fclose(fd);
            $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
            if (fail_count == 0 && pass_count > 0)
                $display("ALL TESTS PASSED");
            else
                $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
+incdir+common
common/nabp_pkg.sv
verilog/nabp_shifter_lut.sv
shifter/nabp_shifter.sv
verilog/nabp_filter_mapper.sv
verilog/nabp_state_control.sv
verilog/nabp_top.sv
sim/nabp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the NABP testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 -f filelist.f --top-module nabp_tb -o nabp_sim || exit 1
out=$(./obj_dir/nabp_sim)
echo "$out"
echo "$out" | grep -qx "ALL TESTS PASSED" && exit 0 || exit 1

// ==== sim/nabp_golden.txt ====
# per test: name, then first_angle angle_count mode (0 plain, 1 stalls on last data, 2 reset)
# then sample count and samples, then column count and expected columns, all in hex
single_half
0 1 0
c 101 102 103 104 105 106 107 108 109 10a 10b 10c
10 104 105 105 106 106 107 107 108 108 109 109 10a 10a 10b 10b 10c
single_full
1 1 0
14 201 202 203 204 205 206 207 208 209 20a 20b 20c 20d 20e 20f 210 211 212 213 214
10 205 206 207 208 209 20a 20b 20c 20d 20e 20f 210 211 212 213 214
single_zero
2 1 0
4 301 302 303 304
10 304 304 304 304 304 304 304 304 304 304 304 304 304 304 304 304
sweep_wrap
5 0 0
5a 401 402 403 404 405 406 407 408 409 40a 40b 40c 40d 40e 40f 410
411 412 413 414 415 416 417 418 419 41a 41b 41c 41d 41e 41f 420
421 422 423 424 425 426 427 428 429 42a 42b 42c 42d 42e 42f 430
431 432 433 434 435 436 437 438 439 43a 43b 43c 43d 43e 43f 440
441 442 443 444 445 446 447 448 449 44a 44b 44c 44d 44e 44f 450
451 452 453 454 455 456 457 458 459 45a
80 404 404 405 405 405 406 406 407 407 407 408 408 408 409 409 40a
40e 40f 40f 410 411 411 412 413 413 414 414 415 416 416 417 418
41c 41c 41c 41c 41c 41c 41c 41d 41d 41d 41d 41d 41d 41d 41d 41e
422 423 423 424 424 425 425 426 426 427 427 428 428 429 429 42a
42f 430 431 432 433 434 435 436 437 438 439 43a 43b 43c 43d 43e
442 442 442 442 442 442 442 442 442 442 442 442 442 442 442 442
446 446 446 447 447 447 447 448 448 448 448 449 449 449 449 44a
44e 44f 450 451 451 452 453 454 454 455 456 457 457 458 459 45a
sweep_stall
5 0 1
reset_rerun
6 1 2
e 601 602 603 604 605 606 607 608 609 60a 60b 60c 60d 60e
10 604 605 605 606 607 607 608 609 609 60a 60a 60b 60c 60c 60d 60e
